// ==== all.f ====
+incdir+common
common/mc_pkg.sv
mem_model/mc_mem_model.sv
hdl/rd_return_fifo.sv
hdl/copy_engine.sv
hdl/copy_top.sv
verif/tb_copy_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the copy_top testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert -j 0 \
   --top-module tb_copy_top \
   -Mdir "${build_dir}" \
   -f all.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./${build_dir}/Vtb_copy_top"
status=$?
if [ ${status} -ne 0 ]; then
   echo "simulation exited with status ${status}"
   exit ${status}
fi

exit 0

// ==== verif/tb_copy_top.sv ====
`timescale 1ns/100ps
`include "mc_defs.svh"

module tb_copy_top;

   localparam int WORDS   = `MC_RAM_WORDS;
   localparam int AW      = $clog2(WORDS);
   localparam int CW      = $clog2(WORDS+1);
   localparam int TIMEOUT = 500;

   logic            clk;
   logic            reset;
   logic            start;
   mc_pkg::eng_op_e op;
   logic [AW-1:0]   src;
   logic [AW-1:0]   dst;
   logic [CW-1:0]   count;
   logic [63:0]     fill_base;
   logic            busy;
   logic            done;
   logic [63:0]     result;

   logic [15:0] lfsr;
   logic [63:0] last_result;
   logic [63:0] shadow [0:WORDS-1];

   copy_top i_dut (
      .clk(clk), .reset(reset), .start(start), .op(op), .src(src), .dst(dst),
      .count(count), .fill_base(fill_base), .busy(busy), .done(done), .result(result)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // --------------------------------------------------
   // random source and reference model
   // --------------------------------------------------
   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[62:0], lfsr[0]};
      end
   endtask

   task automatic pick_len(output int len);
      logic [63:0] r;
      take_bits(4, r);
      len = int'(r) + 1;
   endtask

   // keeps the whole range inside the RAM
   task automatic pick_start(input int len, output int idx);
      logic [63:0] r;
      take_bits(AW, r);
      idx = int'(r);
      if (idx + len > WORDS) idx = WORDS - len;
   endtask

   function automatic logic [63:0] xor_model(input int s, input int n);
      logic [63:0] acc;
      acc = '0;
      for (int i = 0; i < n; i++) acc = acc ^ shadow[s+i];
      return acc;
   endfunction

   // --------------------------------------------------
   // checks and DUT sequencing
   // --------------------------------------------------
   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got == exp) else begin
         $display("ERR %s: got %0h expected %0h", name, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // result must still hold the last value whenever a new start goes out
   task automatic pulse_start(input mc_pkg::eng_op_e o, input int s, input int d,
                              input int n, input logic [63:0] base);
      @(negedge clk);
      check_value("result", result, last_result);
      op        = o;
      src       = AW'(s);
      dst       = AW'(d);
      count     = CW'(n);
      fill_base = base;
      start     = 1'b1;
      @(negedge clk);
      start     = 1'b0;
   endtask

   task automatic wait_done(output logic [63:0] res);
      int cycles;
      cycles = 0;
      while (!done && cycles < TIMEOUT) begin
         check_value("busy", 64'(busy), 64'd1);
         @(negedge clk);
         cycles++;
      end
      assert (done == 1'b1) else begin
         $display("done did not arrive within %0d cycles of start", TIMEOUT);
         $display("SIMULATION FAILED");
         $fatal(1, "timeout");
      end
      check_value("busy", 64'(busy), 64'd1);
      res         = result;
      last_result = result;
      // done lasts one cycle only
      @(negedge clk);
      check_value("done", 64'(done), 64'd0);
      check_value("busy", 64'(busy), 64'd0);
      check_value("result", result, res);
   endtask

   task automatic do_fill(input int d, input int n, input logic [63:0] base);
      logic [63:0] res;
      pulse_start(mc_pkg::OP_FILL, 0, d, n, base);
      wait_done(res);
      check_value("result", res, 64'd0);
      for (int i = 0; i < n; i++) shadow[d+i] = base + 64'(i);
   endtask

   task automatic do_copy(input int s, input int d, input int n);
      logic [63:0] res;
      pulse_start(mc_pkg::OP_COPY, s, d, n, 64'd0);
      wait_done(res);
      check_value("result", res, 64'd0);
      for (int i = 0; i < n; i++) shadow[d+i] = shadow[s+i];
   endtask

   task automatic xor_check(input int s, input int n);
      logic [63:0] res;
      pulse_start(mc_pkg::OP_XOR, s, 0, n, 64'd0);
      wait_done(res);
      check_value("result", res, xor_model(s, n));
   endtask

   // copy range pair with no overlap, optionally of a fixed length
   task automatic copy_round(input int fixed_len);
      int s;
      int d;
      int n;
      n = fixed_len;
      if (n == 0) pick_len(n);
      pick_start(n, s);
      pick_start(n, d);
      if (s < d + n && d < s + n) d = (s >= n) ? s - n : s + n;
      do_copy(s, d, n);
      xor_check(d, n);
      // single-word sums catch words swapped inside the range
      for (int i = 0; i < n; i++) xor_check(d + i, 1);
      // neighbour words past or before the destination
      if (d + n + 8 <= WORDS) xor_check(d + n, 8);
      else xor_check(d - 8, 8);
   endtask

   initial begin
      logic [63:0] base;
      logic [63:0] res;
      int d;
      int n;
      reset       = 1'b1;
      start       = 1'b0;
      op          = mc_pkg::OP_FILL;
      src         = '0;
      dst         = '0;
      count       = '0;
      fill_base   = '0;
      lfsr        = 16'd8;
      last_result = '0;
      repeat (10) @(negedge clk);
      reset = 1'b0;
      check_value("busy", 64'(busy), 64'd0);
      check_value("done", 64'(done), 64'd0);
      check_value("result", result, 64'd0);

      // whole RAM fill then sum, every word gets a known value
      take_bits(64, base);
      do_fill(0, WORDS, base);
      xor_check(0, WORDS);

      repeat (10) begin
         pick_len(n);
         pick_start(n, d);
         take_bits(64, base);
         do_fill(d, n, base);
         xor_check(d, n);
      end

      repeat (10) copy_round(0);
      // full-length copies keep the read limit and FIFO busy
      repeat (4) copy_round(16);

      // second start while busy must be dropped
      take_bits(64, base);
      pulse_start(mc_pkg::OP_XOR, 0, 0, 16, 64'd0);
      @(negedge clk);
      pulse_start(mc_pkg::OP_FILL, 0, 0, 16, base);
      wait_done(res);
      check_value("result", res, xor_model(0, 16));
      xor_check(0, 16);

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// ==== hdl/copy_top.sv ====
`timescale 1ns/100ps
`include "mc_defs.svh"

// fill writes dst..dst+count-1, copy moves src to dst, xor sums src
module copy_top (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 start,
   input  mc_pkg::eng_op_e                      op,
   input  logic [$clog2(`MC_RAM_WORDS)-1:0]     src,
   input  logic [$clog2(`MC_RAM_WORDS)-1:0]     dst,
   input  logic [$clog2(`MC_RAM_WORDS+1)-1:0]   count,
   input  logic [63:0]                          fill_base,
   output logic                                 busy,
   output logic                                 done,
   output logic [63:0]                          result
);

   // request side
   logic                                 mc_rq_vld;
   mc_pkg::mc_rq_cmd_e                   mc_rq_cmd;
   logic [47:0]                          mc_rq_vadr;
   logic [`MC_RTNCTL_WIDTH-1:0]          mc_rq_rtnctl;
   logic [63:0]                          mc_rq_data;

   // response side
   logic                                 mc_rs_vld;
   mc_pkg::mc_rs_cmd_e                   mc_rs_cmd;
   logic [`MC_RTNCTL_WIDTH-1:0]          mc_rs_rtnctl;
   logic [63:0]                          mc_rs_data;

   logic                                 fifo_push;
   logic                                 fifo_pop;
   logic                                 fifo_empty;
   logic [$clog2(`RTN_FIFO_DEPTH+1)-1:0] fifo_count;
   logic [63:0]                          fifo_head_data;
   logic [`MC_RTNCTL_WIDTH-1:0]          fifo_head_tag;

   // only read data is parked, write completions go straight to the engine
   assign fifo_push = mc_rs_vld && (mc_rs_cmd == mc_pkg::MCAE_CMD_RD8_DATA);

   copy_engine i_engine (
      .clk(clk), .reset(reset),
      .start(start), .op(op), .src(src), .dst(dst), .count(count), .fill_base(fill_base),
      .busy(busy), .done(done), .result(result),
      .mc_rq_vld(mc_rq_vld), .mc_rq_cmd(mc_rq_cmd), .mc_rq_vadr(mc_rq_vadr),
      .mc_rq_rtnctl(mc_rq_rtnctl), .mc_rq_data(mc_rq_data),
      .mc_rs_vld(mc_rs_vld), .mc_rs_cmd(mc_rs_cmd),
      .fifo_empty(fifo_empty), .fifo_count(fifo_count),
      .fifo_head_data(fifo_head_data), .fifo_head_tag(fifo_head_tag),
      .fifo_pop(fifo_pop)
   );

   rd_return_fifo i_rtn_fifo (
      .clk(clk), .reset(reset),
      .push(fifo_push), .push_data(mc_rs_data), .push_tag(mc_rs_rtnctl), .pop(fifo_pop),
      .empty(fifo_empty), .count(fifo_count),
      .head_data(fifo_head_data), .head_tag(fifo_head_tag)
   );

   mc_mem_model i_mem (
      .clk(clk), .reset(reset),
      .mc_rq_vld(mc_rq_vld), .mc_rq_cmd(mc_rq_cmd), .mc_rq_vadr(mc_rq_vadr),
      .mc_rq_rtnctl(mc_rq_rtnctl), .mc_rq_data(mc_rq_data),
      .mc_rs_vld(mc_rs_vld), .mc_rs_cmd(mc_rs_cmd),
      .mc_rs_rtnctl(mc_rs_rtnctl), .mc_rs_data(mc_rs_data)
   );

endmodule

// ==== hdl/copy_engine.sv ====
`timescale 1ns/100ps
`include "mc_defs.svh"

module copy_engine (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 start,
   input  mc_pkg::eng_op_e                      op,
   input  logic [$clog2(`MC_RAM_WORDS)-1:0]     src,
   input  logic [$clog2(`MC_RAM_WORDS)-1:0]     dst,
   input  logic [$clog2(`MC_RAM_WORDS+1)-1:0]   count,
   input  logic [63:0]                          fill_base,
   output logic                                 busy,
   output logic                                 done,
   output logic [63:0]                          result,
   output logic                                 mc_rq_vld,
   output mc_pkg::mc_rq_cmd_e                   mc_rq_cmd,
   output logic [47:0]                          mc_rq_vadr,
   output logic [`MC_RTNCTL_WIDTH-1:0]          mc_rq_rtnctl,
   output logic [63:0]                          mc_rq_data,
   input  logic                                 mc_rs_vld,
   input  mc_pkg::mc_rs_cmd_e                   mc_rs_cmd,
   input  logic                                 fifo_empty,
   input  logic [$clog2(`RTN_FIFO_DEPTH+1)-1:0] fifo_count,
   input  logic [63:0]                          fifo_head_data,
   input  logic [`MC_RTNCTL_WIDTH-1:0]          fifo_head_tag,
   output logic                                 fifo_pop
);

   localparam int AW = $clog2(`MC_RAM_WORDS);
   localparam int CW = $clog2(`MC_RAM_WORDS+1);
   localparam int FW = $clog2(`RTN_FIFO_DEPTH+1);
   localparam int TW = `MC_RTNCTL_WIDTH;

   mc_pkg::eng_state_e state;
   mc_pkg::eng_op_e    op_q;
   logic [AW-1:0]      src_q;
   logic [AW-1:0]      dst_q;
   logic [CW-1:0]      cnt_q;
   logic [63:0]        base_q;

   logic [CW-1:0] iss_cnt;      // fill writes or reads issued
   logic [CW-1:0] pop_cnt;      // words taken from the return FIFO
   logic [FW-1:0] rd_out;
   logic [CW-1:0] wr_out;
   logic [63:0]   acc;
   logic [FW:0]   rd_inflight;
   logic [AW-1:0] rd_idx;
   logic [AW-1:0] wr_idx;
   logic [63:0]   wr_data;
   logic          more_iss;
   logic          rd_room;
   logic          issue_rd;
   logic          issue_wr;
   logic          work_issued;
   logic          drained;
   logic          rs_rd;
   logic          rs_wr;

   function automatic logic [47:0] word_to_vadr(input logic [AW-1:0] idx);
      return 48'(idx) << 3;
   endfunction

   assign busy = (state != mc_pkg::ST_IDLE);
   assign done = (state == mc_pkg::ST_DONE);

   assign rs_rd = mc_rs_vld && (mc_rs_cmd == mc_pkg::MCAE_CMD_RD8_DATA);
   assign rs_wr = mc_rs_vld && (mc_rs_cmd == mc_pkg::MCAE_CMD_WR_CMP);

   // reads in flight plus words parked in the FIFO never exceed its depth
   assign rd_inflight = (FW+1)'(rd_out) + (FW+1)'(fifo_count);
   assign rd_room     = (rd_inflight < (FW+1)'(`RTN_FIFO_DEPTH));
   assign more_iss    = (iss_cnt < cnt_q);
   assign drained     = (rd_out == '0) && (wr_out == '0);

   assign rd_idx  = src_q + iss_cnt[AW-1:0];
   assign wr_idx  = (op_q == mc_pkg::OP_COPY) ? dst_q + fifo_head_tag[AW-1:0]
                                              : dst_q + iss_cnt[AW-1:0];
   assign wr_data = (op_q == mc_pkg::OP_COPY) ? fifo_head_data : base_q + 64'(iss_cnt);

   // --------------------------------------------------
   // per-cycle issue decision
   // --------------------------------------------------
   always_comb begin
      issue_rd = 1'b0;
      issue_wr = 1'b0;
      fifo_pop = 1'b0;
      if (state == mc_pkg::ST_RUN) begin
         case (op_q)
            mc_pkg::OP_FILL: issue_wr = more_iss;
            mc_pkg::OP_COPY: begin
               // draining the FIFO head wins over a new read
               if (!fifo_empty) begin
                  issue_wr = 1'b1;
                  fifo_pop = 1'b1;
               end else begin
                  issue_rd = more_iss && rd_room;
               end
            end
            mc_pkg::OP_XOR: begin
               fifo_pop = !fifo_empty;
               issue_rd = more_iss && rd_room;
            end
            default: ;
         endcase
      end
   end

   always_comb begin
      case (op_q)
         mc_pkg::OP_FILL: work_issued = (iss_cnt == cnt_q);
         mc_pkg::OP_COPY,
         mc_pkg::OP_XOR:  work_issued = (pop_cnt == cnt_q);
         default:         work_issued = 1'b1;
      endcase
   end

   // --------------------------------------------------
   // request register
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         mc_rq_vld <= 1'b0;
         mc_rq_cmd <= mc_pkg::AEMC_CMD_IDLE;
      end else begin
         mc_rq_vld <= issue_rd || issue_wr;
         if (issue_wr)      mc_rq_cmd <= mc_pkg::AEMC_CMD_WR8;
         else if (issue_rd) mc_rq_cmd <= mc_pkg::AEMC_CMD_RD8;
         else               mc_rq_cmd <= mc_pkg::AEMC_CMD_IDLE;
      end
   end

   // tag is the word offset within the operation
   always_ff @(posedge clk) begin
      if (issue_wr) begin
         mc_rq_vadr   <= word_to_vadr(wr_idx);
         mc_rq_rtnctl <= (op_q == mc_pkg::OP_COPY) ? fifo_head_tag : TW'(iss_cnt);
         mc_rq_data   <= wr_data;
      end else if (issue_rd) begin
         mc_rq_vadr   <= word_to_vadr(rd_idx);
         mc_rq_rtnctl <= TW'(iss_cnt);
         mc_rq_data   <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if ((state == mc_pkg::ST_IDLE) && start) begin
         op_q   <= op;
         src_q  <= src;
         dst_q  <= dst;
         cnt_q  <= count;
         base_q <= fill_base;
      end
   end

   // --------------------------------------------------
   // FSM and counters
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= mc_pkg::ST_IDLE;
         iss_cnt <= '0;
         pop_cnt <= '0;
         rd_out  <= '0;
         wr_out  <= '0;
         acc     <= '0;
         result  <= '0;
      end else begin
         rd_out <= rd_out + FW'(issue_rd) - FW'(rs_rd);
         wr_out <= wr_out + CW'(issue_wr) - CW'(rs_wr);
         if (issue_rd || (issue_wr && (op_q == mc_pkg::OP_FILL))) begin
            iss_cnt <= iss_cnt + 1'b1;
         end
         if (fifo_pop) begin
            pop_cnt <= pop_cnt + 1'b1;
            if (op_q == mc_pkg::OP_XOR) acc <= acc ^ fifo_head_data;
         end
         case (state)
            mc_pkg::ST_IDLE: begin
               if (start) begin
                  state   <= mc_pkg::ST_RUN;
                  iss_cnt <= '0;
                  pop_cnt <= '0;
                  acc     <= '0;
               end
            end
            mc_pkg::ST_RUN: begin
               if (work_issued) state <= mc_pkg::ST_DRAIN;
            end
            // wait for the last write completions
            mc_pkg::ST_DRAIN: begin
               if (drained) begin
                  state  <= mc_pkg::ST_DONE;
                  result <= (op_q == mc_pkg::OP_XOR) ? acc : '0;
               end
            end
            default: state <= mc_pkg::ST_IDLE;
         endcase
      end
   end

endmodule

// ==== hdl/rd_return_fifo.sv ====
`timescale 1ns/100ps
`include "mc_defs.svh"

module rd_return_fifo (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 push,
   input  logic [63:0]                          push_data,
   input  logic [`MC_RTNCTL_WIDTH-1:0]          push_tag,
   input  logic                                 pop,
   output logic                                 empty,
   output logic [$clog2(`RTN_FIFO_DEPTH+1)-1:0] count,
   output logic [63:0]                          head_data,
   output logic [`MC_RTNCTL_WIDTH-1:0]          head_tag
);

   localparam int DEPTH = `RTN_FIFO_DEPTH;
   localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW    = $clog2(DEPTH+1);

   logic [63:0]                 data_mem [0:DEPTH-1];
   logic [`MC_RTNCTL_WIDTH-1:0] tag_mem  [0:DEPTH-1];
   logic [PW-1:0]               wr_ptr;
   logic [PW-1:0]               rd_ptr;
   logic                        do_push;
   logic                        do_pop;

   function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
      if (p == PW'(DEPTH-1)) return '0;
      return p + 1'b1;
   endfunction

   assign empty     = (count == '0);
   assign head_data = data_mem[rd_ptr];
   assign head_tag  = tag_mem[rd_ptr];

   // a push into a full FIFO only lands when the head leaves this cycle
   assign do_pop  = pop && !empty;
   assign do_push = push && ((count != CW'(DEPTH)) || do_pop);

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
         count <= count + CW'(do_push) - CW'(do_pop);
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         data_mem[wr_ptr] <= push_data;
         tag_mem[wr_ptr]  <= push_tag;
      end
   end

endmodule

// ==== mem_model/mc_mem_model.sv ====
`timescale 1ns/100ps
`include "mc_defs.svh"

module mc_mem_model (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        mc_rq_vld,
   input  mc_pkg::mc_rq_cmd_e          mc_rq_cmd,
   input  logic [47:0]                 mc_rq_vadr,
   input  logic [`MC_RTNCTL_WIDTH-1:0] mc_rq_rtnctl,
   input  logic [63:0]                 mc_rq_data,
   output logic                        mc_rs_vld,
   output mc_pkg::mc_rs_cmd_e          mc_rs_cmd,
   output logic [`MC_RTNCTL_WIDTH-1:0] mc_rs_rtnctl,
   output logic [63:0]                 mc_rs_data
);

   localparam int LAT = `MC_LATENCY;
   localparam int AW  = $clog2(`MC_RAM_WORDS);

   logic [63:0] mem [0:`MC_RAM_WORDS-1];

   // request delay line, entry 0 is the head
   logic                        vld_buf    [0:LAT-1];
   mc_pkg::mc_rq_cmd_e          cmd_buf    [0:LAT-1];
   logic [47:0]                 vadr_buf   [0:LAT-1];
   logic [`MC_RTNCTL_WIDTH-1:0] rtnctl_buf [0:LAT-1];
   logic [63:0]                 data_buf   [0:LAT-1];

   logic [47:0]   head_word;
   logic [AW-1:0] head_idx;

   // byte address to word index
   assign head_word = vadr_buf[0] >> 3;
   assign head_idx  = head_word[AW-1:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < LAT; i++) begin
            vld_buf[i]    <= 1'b0;
            cmd_buf[i]    <= mc_pkg::AEMC_CMD_IDLE;
            vadr_buf[i]   <= '0;
            rtnctl_buf[i] <= '0;
            data_buf[i]   <= '0;
         end
      end else begin
         for (int i = 0; i < LAT-1; i++) begin
            vld_buf[i]    <= vld_buf[i+1];
            cmd_buf[i]    <= cmd_buf[i+1];
            vadr_buf[i]   <= vadr_buf[i+1];
            rtnctl_buf[i] <= rtnctl_buf[i+1];
            data_buf[i]   <= data_buf[i+1];
         end
         // idle slots enter the line as all zero
         vld_buf[LAT-1]    <= mc_rq_vld;
         cmd_buf[LAT-1]    <= mc_rq_vld ? mc_rq_cmd : mc_pkg::AEMC_CMD_IDLE;
         vadr_buf[LAT-1]   <= mc_rq_vld ? mc_rq_vadr : '0;
         rtnctl_buf[LAT-1] <= mc_rq_vld ? mc_rq_rtnctl : '0;
         data_buf[LAT-1]   <= mc_rq_vld ? mc_rq_data : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (vld_buf[0] && (cmd_buf[0] == mc_pkg::AEMC_CMD_WR8)) begin
         mem[head_idx] <= data_buf[0];
      end
   end

   // --------------------------------------------------
   // response register
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset || !vld_buf[0]) begin
         mc_rs_vld    <= 1'b0;
         mc_rs_cmd    <= mc_pkg::MCAE_CMD_IDLE;
         mc_rs_rtnctl <= '0;
         mc_rs_data   <= '0;
      end else begin
         mc_rs_vld    <= 1'b1;
         mc_rs_rtnctl <= rtnctl_buf[0];
         if (cmd_buf[0] == mc_pkg::AEMC_CMD_WR8) begin
            mc_rs_cmd  <= mc_pkg::MCAE_CMD_WR_CMP;
            mc_rs_data <= data_buf[0];
         end else begin
            mc_rs_cmd  <= mc_pkg::MCAE_CMD_RD8_DATA;
            mc_rs_data <= mem[head_idx];
         end
      end
   end

endmodule

// ==== common/mc_pkg.sv ====
package mc_pkg;

   // request commands, engine to memory
   typedef enum logic [2:0] {
      AEMC_CMD_IDLE = 3'd0,
      AEMC_CMD_RD8  = 3'd1,
      AEMC_CMD_WR8  = 3'd2
   } mc_rq_cmd_e;

   // response commands, memory to engine
   typedef enum logic [2:0] {
      MCAE_CMD_IDLE     = 3'd0,
      MCAE_CMD_RD8_DATA = 3'd2,
      MCAE_CMD_WR_CMP   = 3'd3
   } mc_rs_cmd_e;

   typedef enum logic [1:0] {
      OP_FILL = 2'd0,
      OP_COPY = 2'd1,
      OP_XOR  = 2'd2
   } eng_op_e;

   typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DRAIN, ST_DONE} eng_state_e;

endpackage

// ==== common/mc_defs.svh ====
`ifndef MC_DEFS_SVH
`define MC_DEFS_SVH

// --------------------------------------------------
// memory interface sizing
// --------------------------------------------------

// return-control tag carried with every request
`define MC_RTNCTL_WIDTH 32

// depth of the model's word RAM, 64-bit words
`define MC_RAM_WORDS 64

// request buffer stages in the memory model
`define MC_LATENCY 4

// read return FIFO entries, also the cap on reads in flight
`define RTN_FIFO_DEPTH 4

`endif
